//--- array_row.sv
`timescale 1ns/1ps
`default_nettype none

module array_row import mul_pkg::*; #(
    parameter int ROW = 1
) (
    input  wire    clk,
    input  wire    rst_n,
    input  stage_t stage_in,
    output stage_t stage_out
);

    logic [PRODUCT_W-1:0] mcand;
    logic [PRODUCT_W-1:0] pp;
    logic [PRODUCT_W-1:0] row_sum;
    logic [PRODUCT_W-1:0] row_carry;

    // multiplicand for this row, negated on the sign row
    always_comb begin
        mcand = sign_extend(stage_in.a);
        if (ROW == SIGN_ROW) begin
            // sign bit of b has weight -2^ROW
            mcand = ~mcand + PRODUCT_W'(1);
        end
    end

    // partial product, aligned to its bit weight
    always_comb begin
        if (stage_in.b[ROW]) begin
            pp = mcand << ROW;
        end else begin
            pp = '0;
        end
    end

    // 3:2 compressor over pp, sum and carry
    always_comb begin
        row_carry[0] = 1'b0;
        for (int i = 0; i < PRODUCT_W; i++) begin
            row_sum[i] = pp[i] ^ stage_in.sum[i] ^ stage_in.carry[i];
        end
        // carry out of the top bit falls off, arithmetic is mod 2^PRODUCT_W
        for (int i = 0; i < PRODUCT_W - 1; i++) begin
            row_carry[i+1] = (pp[i] & stage_in.sum[i])
                           | (pp[i] & stage_in.carry[i])
                           | (stage_in.sum[i] & stage_in.carry[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_out <= '0;
        end else begin
            stage_out.valid <= stage_in.valid;
            stage_out.a     <= stage_in.a;
            stage_out.b     <= stage_in.b;
            stage_out.sum   <= row_sum;
            stage_out.carry <= row_carry;
        end
    end

    // the 3:2 row keeps pp + sum + carry modulo 2^PRODUCT_W
    property p_row_keeps_total;
        @(posedge clk) disable iff (!rst_n)
            stage_in.valid |-> (row_sum + row_carry == pp + stage_in.sum + stage_in.carry);
    endproperty

    a_row_keeps_total: assert property (p_row_keeps_total)
        else $error("array_row %0d compressor lost its total", ROW);

endmodule

`default_nettype wire

//--- compile.f
mul_pkg.sv
operand_capture.sv
array_row.sv
final_adder.sv
mul_top.sv
tb_mul_top.sv

//--- final_adder.sv
`timescale 1ns/1ps
`default_nettype none

module final_adder import mul_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,
    input  stage_t   stage_in,
    output logic     out_valid,
    output product_t product
);

    logic [PRODUCT_W-1:0] resolved;

    // ripple carry-propagate row, sum + carry into one word
    always_comb begin
        logic ripple;
        ripple = 1'b0;
        for (int i = 0; i < PRODUCT_W; i++) begin
            resolved[i] = stage_in.sum[i] ^ stage_in.carry[i] ^ ripple;
            ripple      = (stage_in.sum[i] & stage_in.carry[i])
                        | (stage_in.sum[i] & ripple)
                        | (stage_in.carry[i] & ripple);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= stage_in.valid;
        end
    end

    // hold last product between strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product <= '0;
        end else if (stage_in.valid) begin
            product <= $signed(resolved);
        end
    end

    property p_out_valid_known;
        @(posedge clk) disable iff (!rst_n)
            !$isunknown(out_valid);
    endproperty

    a_out_valid_known: assert property (p_out_valid_known)
        else $error("out_valid is unknown");

endmodule

`default_nettype wire

//--- mul_pkg.sv
`default_nettype none

package mul_pkg;

    // operand and product widths
    localparam int OPERAND_W = 9;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // one partial-product row per multiplier bit
    localparam int NUM_ROWS = OPERAND_W;

    // the row for the multiplier's sign bit adds -a
    localparam int SIGN_ROW = NUM_ROWS - 1;

    // capture stage + eight array rows + final adder
    localparam int LATENCY = 1 + (NUM_ROWS - 1) + 1;

    typedef logic signed [OPERAND_W-1:0] operand_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;

    // one pipeline slot, operands travel with their partial sums
    typedef struct packed {
        logic                 valid;
        operand_t             a;
        operand_t             b;
        logic [PRODUCT_W-1:0] sum;
        logic [PRODUCT_W-1:0] carry;
    } stage_t;

    // widen an operand to product width, keeping its sign
    function automatic logic [PRODUCT_W-1:0] sign_extend(operand_t x);
        logic [PRODUCT_W-1:0] wide;
        wide = {{(PRODUCT_W - OPERAND_W){x[OPERAND_W-1]}}, x};
        return wide;
    endfunction

endpackage

`default_nettype wire

//--- mul_testdata.txt
# columns: multiplicand a, multiplier b, expected signed product, all decimal
# operands are 9-bit signed, -256 to 255
0 0 0
0 255 0
0 -256 0
0 -1 0
255 0 0
-256 0 0
-1 0 0
1 -1 -1
-1 1 -1
1 1 1
-1 -1 1
1 255 255
1 -256 -256
255 1 255
-256 1 -256
-1 255 -255
-1 -256 256
255 -1 -255
-256 -1 256
255 255 65025
-256 255 -65280
255 -256 -65280
-256 -256 65536
255 -255 -65025
-255 -255 65025
-255 255 -65025
-256 -255 65280
170 170 28900
170 -171 -29070
-171 170 -29070
-171 -171 29241
85 85 7225
85 -86 -7310
-86 -86 7396
170 85 14450
-171 -86 14706
2 128 256
128 2 256
128 128 16384
-128 128 -16384
-128 -128 16384
128 -256 -32768
-256 128 -32768
127 127 16129
-127 127 -16129
127 -128 -16256
3 3 9
-3 7 -21
7 -3 -21
100 100 10000
-100 100 -10000
-100 -100 10000
200 -150 -30000
-150 200 -30000
123 -45 -5535
-45 123 -5535
99 -99 -9801
250 250 62500
-250 -250 62500
-250 250 -62500
2 -256 -512
-256 2 -512
64 64 4096
-64 -64 4096
16 -16 -256
42 17 714
-42 17 -714
17 -42 -714
-42 -17 714
255 2 510
-256 -2 512
13 19 247
-13 -19 247
111 222 24642
-111 222 -24642
222 -111 -24642
201 -77 -15477
-77 201 -15477
63 -64 -4032
-65 65 -4225
31 33 1023
-31 -33 1023
129 -130 -16770
-130 129 -16770
254 -253 -64262
-253 254 -64262
-254 -253 64262
5 -255 -1275
-255 5 -1275

//--- mul_top.sv
`timescale 1ns/1ps
`default_nettype none

module mul_top import mul_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,
    input  logic     in_valid,
    input  operand_t in_a,
    input  operand_t in_b,
    output logic     out_valid,
    output product_t product
);

    // stage[0] from capture, stage[k] out of array row k
    stage_t stage [0:NUM_ROWS-1];

    operand_capture operand_capture_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_a      (in_a),
        .in_b      (in_b),
        .stage_out (stage[0])
    );

    // rows 1 to SIGN_ROW, one pipeline stage each
    for (genvar row = 1; row < NUM_ROWS; row++) begin : g_row
        array_row #(
            .ROW (row)
        ) array_row_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .stage_in  (stage[row-1]),
            .stage_out (stage[row])
        );
    end

    final_adder final_adder_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage_in  (stage[NUM_ROWS-1]),
        .out_valid (out_valid),
        .product   (product)
    );

endmodule

`default_nettype wire

//--- operand_capture.sv
`timescale 1ns/1ps
`default_nettype none

module operand_capture import mul_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,
    input  logic     in_valid,
    input  operand_t in_a,
    input  operand_t in_b,
    output stage_t   stage_out
);

    logic [PRODUCT_W-1:0] a_wide;
    logic [PRODUCT_W-1:0] row0;

    // row 0 is a plain and-row, nothing to add yet
    always_comb begin
        a_wide = sign_extend(in_a);
        row0   = a_wide & {PRODUCT_W{in_b[0]}};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_out <= '0;
        end else begin
            stage_out.valid <= in_valid;
            stage_out.a     <= in_a;
            stage_out.b     <= in_b;
            stage_out.sum   <= row0;
            // carry vector starts empty
            stage_out.carry <= '0;
        end
    end

    // an accepted pair must carry known operands
    property p_operands_known;
        @(posedge clk) disable iff (!rst_n)
            in_valid |-> !$isunknown({in_a, in_b});
    endproperty

    a_operands_known: assert property (p_operands_known)
        else $error("operands unknown while in_valid is high");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_mul_top \
    -f compile.f \
    -o sim_mul

./obj_dir/sim_mul 2>&1 | tee "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0

//--- tb_mul_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mul_top import mul_pkg::*; ();

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    operand_t in_a;
    operand_t in_b;
    logic     out_valid;
    product_t product;

    // expected value that rides along with the driven pair
    logic signed [63:0] drive_exp;

    // expected value of the most recent output
    logic signed [63:0] last_exp = '0;

    logic signed [63:0] exp_q [$];
    int                 ts_q [$];
    operand_t           dir_a [$];
    operand_t           dir_b [$];
    logic signed [63:0] dir_exp [$];

    int cycle = 0;
    int cycle_limit = 100000;
    int n_pass = 0;
    int n_fail = 0;
    int n_strobes = 0;
    int n_outputs = 0;
    int max_in_flight = 0;
    int seed;

    mul_top mul_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_a      (in_a),
        .in_b      (in_b),
        .out_valid (out_valid),
        .product   (product)
    );

    always #20 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_equal(input string what, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR at %0t ns: %s expected %0d got %0d", $time, what, expected, actual);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    function automatic logic signed [63:0] signed_product(input operand_t a, input operand_t b);
        logic signed [63:0] wa;
        logic signed [63:0] wb;
        wa = 64'(a);
        wb = 64'(b);
        return wa * wb;
    endfunction

    task automatic drive_pair(input operand_t a, input operand_t b,
                              input logic signed [63:0] exp_val);
        @(posedge clk);
        in_valid  <= 1'b1;
        in_a      <= a;
        in_b      <= b;
        drive_exp <= exp_val;
    endtask

    // idle cycles carry fresh operands that must not reach the output
    task automatic go_idle(input int n);
        logic [31:0] r;
        repeat (n) begin
            @(posedge clk);
            r = $random(seed);
            in_valid <= 1'b0;
            in_a     <= r[8:0];
            in_b     <= r[17:9];
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (n_fail == fails_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, n_fail - fails_before);
        end
    endtask

    // scoreboard, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        logic signed [63:0] exp_val;
        int                 ts;
        if (out_valid === 1'b1) begin
            n_outputs++;
            if (exp_q.size() == 0) begin
                $display("out_valid rose at %0t ns with no pair in flight", $time);
                n_fail++;
            end else begin
                exp_val = exp_q.pop_front();
                ts = ts_q.pop_front();
                last_exp = exp_val;
                check_equal("product", exp_val, 64'(product));
                check_equal("latency", 64'(LATENCY), 64'(cycle - ts));
            end
        end
        // in_valid here is what the DUT samples at the next edge
        if (in_valid === 1'b1) begin
            n_strobes++;
            exp_q.push_back(drive_exp);
            ts_q.push_back(cycle);
            if (exp_q.size() > max_in_flight) begin
                max_in_flight = exp_q.size();
            end
        end
    end

    initial begin
        int          fd;
        int          rc;
        int          va;
        int          vb;
        int          vexp;
        int          fails_before;
        int          strobes_before;
        int          outputs_before;
        string       line;
        logic [31:0] rnd;
        logic [1:0]  gap;
        operand_t    ra;
        operand_t    rb;

        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_a      = '0;
        in_b      = '0;
        drive_exp = '0;
        seed      = 42421;

        fd = $fopen("mul_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open mul_testdata.txt");
            n_fail++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%d %d %d", va, vb, vexp) == 3) begin
                        dir_a.push_back(va[8:0]);
                        dir_b.push_back(vb[8:0]);
                        dir_exp.push_back(64'(vexp));
                    end
                end
            end
            $fclose(fd);
        end
        if (dir_a.size() == 0) begin
            $display("the data file held no directed pairs");
            n_fail++;
        end
        cycle_limit = 16 + (dir_a.size() + 300) * 3 + LATENCY + 100;

        fails_before = n_fail;
        repeat (16) begin
            @(negedge clk);
            check_equal("out_valid in reset", 64'sd0, 64'(out_valid));
            check_equal("product in reset", 64'sd0, 64'(product));
        end
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_equal("out_valid after reset", 64'sd0, 64'(out_valid));
            check_equal("product after reset", 64'sd0, 64'(product));
        end
        report_test("reset", fails_before);

        fails_before = n_fail;
        for (int i = 0; i < dir_a.size(); i++) begin
            drive_pair(dir_a[i], dir_b[i], dir_exp[i]);
        end
        go_idle(1);
        wait_drain();
        report_test("directed", fails_before);

        // back to back, the pipe fills completely
        fails_before = n_fail;
        max_in_flight = 0;
        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            ra = rnd[8:0];
            rnd = $random(seed);
            rb = rnd[8:0];
            drive_pair(ra, rb, signed_product(ra, rb));
        end
        go_idle(1);
        wait_drain();
        check_equal("pairs in flight", 64'(LATENCY), 64'(max_in_flight));
        report_test("streaming", fails_before);

        fails_before = n_fail;
        strobes_before = n_strobes;
        outputs_before = n_outputs;
        for (int i = 0; i < 100; i++) begin
            rnd = $random(seed);
            ra = rnd[8:0];
            rb = rnd[17:9];
            gap = rnd[19:18];
            drive_pair(ra, rb, signed_product(ra, rb));
            go_idle(int'(gap));
        end
        go_idle(1);
        wait_drain();
        check_equal("out_valid pulses", 64'(n_strobes - strobes_before),
                    64'(n_outputs - outputs_before));
        report_test("gapped", fails_before);

        fails_before = n_fail;
        repeat (20) begin
            go_idle(1);
            @(negedge clk);
            check_equal("out_valid while idle", 64'sd0, 64'(out_valid));
            check_equal("held product", last_exp, 64'(product));
        end
        report_test("hold", fails_before);

        $display("checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
